// ==== common/tlb_pkg.sv ====
package tlb_pkg;

  // geometry of the code-side translation buffer.
  localparam int way_count = 8;
  localparam int set_count = 64;
  localparam int set_bits = 6;                // index width, log2 of set_count.
  localparam int rank_bits = 3;               // recency rank, 0 is the next victim.

  // address split of a fetch address.
  localparam int page_shift = 12;             // 4k pages.
  localparam int vpn_bits = 36;               // page number is addr[47:12].
  localparam int ctx_bits = 16;

  // translation result fields.
  localparam int pfn_bits = 28;
  localparam int perm_bits = 3;

  // translation result as returned on a hit and supplied on a fill.
  typedef struct packed {
    logic [pfn_bits-1:0]  pfn;                // physical frame number.
    logic                 glob;               // global page, matches any context.
    logic [perm_bits-1:0] perm;               // permission bits, passed through.
  } tlb_data_t;

  // one stored entry of a way.
  typedef struct packed {
    logic                valid;
    logic [ctx_bits-1:0] ctx;                 // context the entry was filled under.
    logic [vpn_bits-1:0] tag;                 // full page number.
    tlb_data_t           data;
  } tlb_entry_t;

  // cleared entry written by the init sweep.
  localparam tlb_entry_t entry_empty = '{
    valid: 1'b0,
    ctx:   '0,
    tag:   '0,
    data:  '0
  };

endpackage

// ==== common/csr_pkg.sv ====
package csr_pkg;

  localparam int thread_count = 2;

  // register-bus addresses snooped by the buffer.
  localparam logic [15:0] csr_ctx_addr = 16'h0180;
  localparam logic [15:0] csr_flags_addr = 16'h0181;

  // one write on the register bus.
  typedef struct packed {
    logic        en;
    logic [15:0] addr;
    logic [63:0] data;
  } csr_wr_t;

  // context register half, one per thread.
  typedef struct packed {
    logic [31-tlb_pkg::ctx_bits:0] rsvd;
    logic [tlb_pkg::ctx_bits-1:0]  id;        // context id in the low bits.
  } ctx_half_t;

  // mode-flags register half, one per thread.
  typedef struct packed {
    logic [30:0] rsvd;
    logic        vm_en;                       // virtualization enable.
  } flags_half_t;

  // a register word seen either as contexts or as mode flags.
  typedef union packed {
    ctx_half_t   [thread_count-1:0] ctx_view;
    flags_half_t [thread_count-1:0] flags_view;
  } csr_word_u;

endpackage

// ==== logic/csr_watch.sv ====
module csr_watch #(
  parameter logic [15:0] csr_addr = 16'h0000
) (
  input  logic               clk,
  input  logic               rst,
  input  csr_pkg::csr_wr_t   csr_wr,
  output csr_pkg::csr_word_u word
);

  logic hit_wr;

  // only a write to our own address is captured.
  assign hit_wr = csr_wr.en && (csr_wr.addr == csr_addr);

  // the raw word is held, the reader picks the view.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      word <= '0;                             // context 0, virtualization off.
    end
    else if (hit_wr)
    begin
      word <= csr_wr.data;
    end
  end

endmodule

// ==== ctlb/ctlb_lru.sv ====
module ctlb_lru (
  input  logic [tlb_pkg::rank_bits-1:0] rank_old,
  input  logic [tlb_pkg::rank_bits-1:0] rank_ref,
  output logic [tlb_pkg::rank_bits-1:0] rank_new
);

  import tlb_pkg::*;

  // most recently used rank.
  localparam logic [rank_bits-1:0] rank_top = rank_bits'(way_count - 1);

  logic is_ref;
  logic is_above;

  assign is_ref = (rank_old == rank_ref);
  assign is_above = (rank_old > rank_ref);

  // the referenced way moves to the top, the ones above it close the gap.
  // ranks below the referenced one keep their order.
  always_comb
  begin
    if (is_ref)
    begin
      rank_new = rank_top;
    end
    else if (is_above)
    begin
      rank_new = rank_old - 1'b1;
    end
    else
    begin
      rank_new = rank_old;
    end
  end

endmodule

// ==== ctlb/ctlb_way.sv ====
module ctlb_way #(
  parameter int way_no = 0
) (
  input  logic                          clk,
  input  logic [tlb_pkg::set_bits-1:0]  index,
  input  logic [tlb_pkg::vpn_bits-1:0]  vpn,
  input  logic [tlb_pkg::ctx_bits-1:0]  ctx,
  input  logic                          entry_wr,
  input  tlb_pkg::tlb_data_t            fill_data,
  input  logic                          init,
  input  logic [tlb_pkg::rank_bits-1:0] rank_new,
  input  logic                          rank_wr,
  output logic                          hit,
  output tlb_pkg::tlb_data_t            data,
  output logic [tlb_pkg::rank_bits-1:0] rank
);

  import tlb_pkg::*;

  // the init sweep seeds ranks with the way number, which is a permutation.
  localparam logic [rank_bits-1:0] rank_init = rank_bits'(way_no);

  tlb_entry_t           entries [set_count];
  logic [rank_bits-1:0] ranks [set_count];

  tlb_entry_t           entry_rd;
  tlb_entry_t           entry_fill;
  tlb_entry_t           entry_next;
  logic                 entry_we;
  logic [rank_bits-1:0] rank_next;
  logic                 rank_we;
  logic                 tag_eq;
  logic                 ctx_ok;

  // combinational read at the presented index.
  assign entry_rd = entries[index];
  assign rank = ranks[index];

  assign tag_eq = (entry_rd.tag == vpn);
  assign ctx_ok = entry_rd.data.glob || (entry_rd.ctx == ctx);
  assign hit = entry_rd.valid && tag_eq && ctx_ok;

  // zero on a miss so the top can simply OR the ways together.
  assign data = hit ? entry_rd.data : '0;

  always_comb
  begin
    entry_fill.valid = 1'b1;
    entry_fill.ctx = ctx;
    entry_fill.tag = vpn;
    entry_fill.data = fill_data;
  end

  // init wins over a fill.
  assign entry_next = init ? entry_empty : entry_fill;
  assign entry_we = init || entry_wr;

  assign rank_next = init ? rank_init : rank_new;
  assign rank_we = init || rank_wr;

  always_ff @(posedge clk)
  begin
    if (entry_we)
    begin
      entries[index] <= entry_next;
    end
    if (rank_we)
    begin
      ranks[index] <= rank_next;
    end
  end

endmodule

// ==== ctlb/ctlb.sv ====
module ctlb (
  input  logic               clk,
  input  logic               rst,
  input  logic               lookup_en,
  input  logic               lookup_thread,
  input  logic [63:0]        lookup_addr,
  input  logic               stall,
  input  logic               fill_en,
  input  tlb_pkg::tlb_data_t fill_data,
  input  csr_pkg::csr_wr_t   csr_wr,
  output logic               lookup_hit,
  output tlb_pkg::tlb_data_t lookup_data,
  output logic               init_busy
);

  import tlb_pkg::*;
  import csr_pkg::*;

  logic [set_bits-1:0] init_cnt;
  logic [vpn_bits-1:0] vpn;
  logic [set_bits-1:0] index;
  logic [ctx_bits-1:0] cur_ctx;
  csr_word_u           ctx_word;
  csr_word_u           flags_word;

  logic [way_count-1:0]                way_hit;
  tlb_data_t                           way_data [way_count];
  logic [way_count-1:0][rank_bits-1:0] way_rank;
  logic [way_count-1:0][rank_bits-1:0] rank_new;
  logic [way_count-1:0]                victim;
  logic [way_count-1:0]                entry_wr;

  logic                 any_hit;
  tlb_data_t            hit_data;
  logic [rank_bits-1:0] hit_rank;
  logic [rank_bits-1:0] rank_ref;
  logic                 fill_do;
  logic                 upd_do;

  assign vpn = lookup_addr[page_shift +: vpn_bits];
  assign index = init_busy ? init_cnt : vpn[set_bits-1:0];   // sweep takes the index.

  // context id only counts when virtualization is on for the thread.
  assign cur_ctx = flags_word.flags_view[lookup_thread].vm_en ?
                   ctx_word.ctx_view[lookup_thread].id : '0;

  csr_watch #(.csr_addr(csr_ctx_addr)) ctx_watch (
    .clk    (clk),
    .rst    (rst),
    .csr_wr (csr_wr),
    .word   (ctx_word)
  );

  csr_watch #(.csr_addr(csr_flags_addr)) flags_watch (
    .clk    (clk),
    .rst    (rst),
    .csr_wr (csr_wr),
    .word   (flags_word)
  );

  assign fill_do = fill_en && !init_busy;
  assign upd_do = lookup_en && any_hit && !stall && !fill_en && !init_busy;

  // a fill always references rank 0, the victim.
  assign rank_ref = fill_do ? '0 : hit_rank;

  for (genvar k = 0; k < way_count; k++)
  begin : g_way
    assign victim[k] = (way_rank[k] == '0);
    assign entry_wr[k] = fill_do && victim[k];

    ctlb_way #(.way_no(k)) way (
      .clk       (clk),
      .index     (index),
      .vpn       (vpn),
      .ctx       (cur_ctx),
      .entry_wr  (entry_wr[k]),
      .fill_data (fill_data),
      .init      (init_busy),
      .rank_new  (rank_new[k]),
      .rank_wr   (fill_do || upd_do),
      .hit       (way_hit[k]),
      .data      (way_data[k]),
      .rank      (way_rank[k])
    );

    ctlb_lru lru (
      .rank_old (way_rank[k]),
      .rank_ref (rank_ref),
      .rank_new (rank_new[k])
    );
  end

  // at most one way hits, so OR-ing the gated values selects it.
  always_comb
  begin
    hit_data = '0;
    hit_rank = '0;
    for (int k = 0; k < way_count; k++)
    begin
      hit_data = hit_data | way_data[k];
      if (way_hit[k])
      begin
        hit_rank = hit_rank | way_rank[k];
      end
    end
  end

  assign any_hit = |way_hit;
  assign lookup_hit = any_hit && !init_busy;
  assign lookup_data = lookup_hit ? hit_data : '0;

  // init sweep, one set per cycle after reset.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      init_busy <= 1'b1;
      init_cnt <= '0;
    end
    else if (init_busy)
    begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == set_bits'(set_count - 1))
      begin
        init_busy <= 1'b0;                    // last set cleared.
      end
    end
  end

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock #(
  parameter int period = 20
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  always #(period / 2) clk = ~clk;            // free running, first rise at half a period.

endmodule

// ==== dv/ctlb_chk.sv ====
module ctlb_chk (
  input logic                          clk,
  input logic                          rst,
  input logic                          init_busy,
  input logic                          lookup_hit,
  input logic [tlb_pkg::way_count-1:0] way_hit
);

  int assert_fails = 0;                       // read by the testbench at the end.

  // nothing may hit while the sweep still clears sets.
  no_hit_in_init: assert property (@(posedge clk) disable iff (rst)
    init_busy |-> !lookup_hit)
  else
  begin
    $error("lookup hit while the init sweep is running");
    assert_fails++;
  end

  single_way_hit: assert property (@(posedge clk) disable iff (rst)
    !init_busy |-> $onehot0(way_hit))
  else
  begin
    $error("more than one way hits the same page");
    assert_fails++;
  end

  // the sweep runs once per reset.
  init_stays_done: assert property (@(posedge clk) disable iff (rst)
    !init_busy |=> !init_busy)
  else
  begin
    $error("init_busy rose again after the sweep finished");
    assert_fails++;
  end

endmodule

bind ctlb ctlb_chk chk (
  .clk        (clk),
  .rst        (rst),
  .init_busy  (init_busy),
  .lookup_hit (lookup_hit),
  .way_hit    (way_hit)
);

// ==== dv/ctlb_tb.sv ====
module ctlb_tb;

  import tlb_pkg::*;
  import csr_pkg::*;

  localparam int clk_period = 20;
  localparam int pool_size = 40;
  localparam int basic_cycles = 400;
  localparam int ctx_cycles = 400;
  localparam int repl_cycles = 800;
  localparam int directed_cycles = 64;
  localparam int init_limit = set_count + 8;
  localparam int watchdog_cycles = 2 + init_limit + basic_cycles + ctx_cycles
                                   + repl_cycles + directed_cycles + 200;

  logic        clk;
  logic        rst;
  logic        lookup_en;
  logic        lookup_thread;
  logic [63:0] lookup_addr;
  logic        stall;
  logic        fill_en;
  tlb_data_t   fill_data;
  csr_wr_t     csr_wr;
  logic        lookup_hit;
  tlb_data_t   lookup_data;
  logic        init_busy;

  int seed;
  int err_cnt;
  int check_cnt;

  // reference copy of the buffer and both registers.
  logic                 m_valid [set_count][way_count];
  logic [ctx_bits-1:0]  m_ctx [set_count][way_count];
  logic [vpn_bits-1:0]  m_tag [set_count][way_count];
  tlb_data_t            m_data [set_count][way_count];
  logic [rank_bits-1:0] m_rank [set_count][way_count];
  logic [63:0]          m_ctx_reg;
  logic [63:0]          m_flags_reg;

  logic [vpn_bits-1:0] pool [pool_size];

  tb_clock #(.period(clk_period)) clock_gen (
    .clk (clk)
  );

  ctlb UUT (
    .clk           (clk),
    .rst           (rst),
    .lookup_en     (lookup_en),
    .lookup_thread (lookup_thread),
    .lookup_addr   (lookup_addr),
    .stall         (stall),
    .fill_en       (fill_en),
    .fill_data     (fill_data),
    .csr_wr        (csr_wr),
    .lookup_hit    (lookup_hit),
    .lookup_data   (lookup_data),
    .init_busy     (init_busy)
  );

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic bit chance(input int pct);
    return rand_below(100) < pct;
  endfunction

  // random bits above the page number and in the page offset must not matter.
  function automatic logic [63:0] addr_of(input logic [vpn_bits-1:0] page);
    logic [15:0] hi;
    logic [11:0] off;
    hi = $random(seed);
    off = $random(seed);
    return {hi, page, off};
  endfunction

  function automatic logic [ctx_bits-1:0] pick_ctx();
    case (rand_below(3))
      0: return 16'h0000;
      1: return 16'h1234;
      default: return 16'h00a5;
    endcase
  endfunction

  function automatic csr_wr_t random_csr();
    csr_wr_t w;
    int pick;
    pick = rand_below(3);
    w.en = 1'b1;
    w.data = {$random(seed), $random(seed)};
    if (pick == 0)
    begin
      w.addr = csr_ctx_addr;
      w.data[15:0] = pick_ctx();              // thread 0 id.
      w.data[47:32] = pick_ctx();             // thread 1 id.
    end
    else if (pick == 1)
      w.addr = csr_flags_addr;
    else
      w.addr = 16'h0182;                      // neighbour register that must be ignored.
    return w;
  endfunction

  function automatic logic [ctx_bits-1:0] cur_context(input logic thr);
    int base;
    base = thr ? 32 : 0;
    if (m_flags_reg[base])
      return m_ctx_reg[base +: ctx_bits];
    else
      return '0;
  endfunction

  // a fill may only replace the way that already holds the page.
  function automatic bit fill_safe(input logic [vpn_bits-1:0] page);
    int set;
    set = page[set_bits-1:0];
    for (int w = 0; w < way_count; w++)
    begin
      if (m_valid[set][w] && m_tag[set][w] == page && m_rank[set][w] != 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic age_set(input int set, input logic [rank_bits-1:0] ref_rank);
    for (int w = 0; w < way_count; w++)
    begin
      if (m_rank[set][w] == ref_rank)
        m_rank[set][w] = way_count - 1;       // referenced way becomes newest.
      else if (m_rank[set][w] > ref_rank)
        m_rank[set][w] = m_rank[set][w] - 1;
    end
  endtask

  task automatic model_reset();
    for (int s = 0; s < set_count; s++)
    begin
      for (int w = 0; w < way_count; w++)
      begin
        m_valid[s][w] = 1'b0;
        m_rank[s][w] = w;
      end
    end
    m_ctx_reg = '0;
    m_flags_reg = '0;
  endtask

  // compares this cycle's outputs, then applies the coming clock edge to the model.
  task automatic model_cycle();
    logic [vpn_bits-1:0]  page;
    logic [ctx_bits-1:0]  ctx;
    logic                 exp_hit;
    tlb_data_t            exp_data;
    int                   set;
    int                   hit_way;
    int                   victim;
    page = lookup_addr[47:12];
    set = page[set_bits-1:0];
    ctx = cur_context(lookup_thread);
    exp_hit = 1'b0;
    exp_data = '0;
    hit_way = 0;
    victim = 0;
    for (int w = 0; w < way_count; w++)
    begin
      if (m_valid[set][w] && m_tag[set][w] == page
          && (m_data[set][w].glob || m_ctx[set][w] == ctx))
      begin
        exp_hit = 1'b1;
        exp_data = m_data[set][w];
        hit_way = w;
      end
    end
    check_cnt++;
    if (init_busy !== 1'b0)
    begin
      $display("Mismatch at %0t: init_busy %b after the sweep", $time, init_busy);
      err_cnt++;
    end
    if (lookup_hit !== exp_hit)
    begin
      $display("Mismatch at %0t: page %h hit %b expected %b", $time, page, lookup_hit, exp_hit);
      err_cnt++;
    end
    if (lookup_data !== exp_data)
    begin
      $display("Mismatch at %0t: page %h data %h expected %h", $time, page, lookup_data,
               exp_data);
      err_cnt++;
    end
    if (fill_en)
    begin
      for (int w = 0; w < way_count; w++)
      begin
        if (m_rank[set][w] == 0)
          victim = w;
      end
      m_valid[set][victim] = 1'b1;
      m_ctx[set][victim] = ctx;
      m_tag[set][victim] = page;
      m_data[set][victim] = fill_data;
      age_set(set, 0);
    end
    else if (lookup_en && exp_hit && !stall)
      age_set(set, m_rank[set][hit_way]);
    if (csr_wr.en && csr_wr.addr == csr_ctx_addr)
      m_ctx_reg = csr_wr.data;
    if (csr_wr.en && csr_wr.addr == csr_flags_addr)
      m_flags_reg = csr_wr.data;
  endtask

  task automatic run_cycle(input logic en, input logic thr, input logic [63:0] addr,
                           input logic stl, input logic fen, input tlb_data_t fdata,
                           input csr_wr_t cwr);
    @(posedge clk);
    #2;
    lookup_en = en;
    lookup_thread = thr;
    lookup_addr = addr;
    stall = stl;
    fill_en = fen;
    fill_data = fdata;
    csr_wr = cwr;
    #6;
    model_cycle();
  endtask

  task automatic write_csr(input logic [15:0] addr, input logic [63:0] data);
    csr_wr_t w;
    w.en = 1'b1;
    w.addr = addr;
    w.data = data;
    run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, '0, w);
  endtask

  task automatic fill_page(input logic thr, input logic [vpn_bits-1:0] page,
                           input logic glob, input logic stl);
    tlb_data_t d;
    d = $random(seed);
    d.glob = glob;
    run_cycle(1'b1, thr, addr_of(page), stl, 1'b1, d, '0);
  endtask

  task automatic expect_lookup(input logic thr, input logic [vpn_bits-1:0] page,
                               input logic exp, input logic stl);
    run_cycle(1'b1, thr, addr_of(page), stl, 1'b0, '0, '0);
    if (lookup_hit !== exp)
    begin
      $display("Mismatch at %0t: directed lookup of %h hit %b expected %b", $time, page,
               lookup_hit, exp);
      err_cnt++;
    end
  endtask

  task automatic check_init();
    int busy_cycles;
    busy_cycles = 0;
    while (init_busy === 1'b1 && busy_cycles < init_limit)
    begin
      lookup_en = chance(70);
      lookup_thread = chance(50);
      lookup_addr = {$random(seed), $random(seed)};
      fill_en = chance(30);                   // must be ignored during the sweep.
      fill_data = $random(seed);
      #6;
      if (lookup_hit !== 1'b0 || lookup_data !== '0)
      begin
        $display("Mismatch at %0t: hit %b data %h during init", $time, lookup_hit,
                 lookup_data);
        err_cnt++;
      end
      busy_cycles++;
      @(posedge clk);
      #2;
    end
    lookup_en = 1'b0;
    fill_en = 1'b0;
    if (busy_cycles != set_count)
    begin
      $display("Mismatch at %0t: init_busy high for %0d cycles, expected %0d", $time,
               busy_cycles, set_count);
      err_cnt++;
    end
  endtask

  task automatic make_pool(input int span);
    logic [29:0] hi;
    int set;
    for (int i = 0; i < pool_size; i++)
    begin
      hi = $random(seed);
      set = (span >= set_count) ? rand_below(set_count) : 3 + 7 * rand_below(span);
      pool[i] = {hi, set_bits'(set)};
    end
  endtask

  task automatic random_cycles(input int n, input int fill_pct, input int stall_pct,
                               input int csr_pct);
    logic [vpn_bits-1:0] page;
    logic                en;
    logic                thr;
    logic                stl;
    logic                fen;
    tlb_data_t           fdata;
    csr_wr_t             cwr;
    for (int i = 0; i < n; i++)
    begin
      page = pool[rand_below(pool_size)];
      en = chance(70);
      thr = chance(50);
      stl = chance(stall_pct);
      fen = chance(fill_pct) && fill_safe(page);
      fdata = $random(seed);
      cwr = chance(csr_pct) ? random_csr() : '0;
      run_cycle(en, thr, addr_of(page), stl, fen, fdata, cwr);
    end
  endtask

  task automatic context_directed();
    logic [vpn_bits-1:0] pa;
    logic [vpn_bits-1:0] pb;
    logic [vpn_bits-1:0] pc;
    pa = {30'($random(seed)), 6'd20};
    pb = {30'($random(seed)), 6'd21};
    pc = {30'($random(seed)), 6'd22};
    write_csr(csr_ctx_addr, {16'h0, 16'h00a5, 16'h0, 16'h1234});
    write_csr(csr_flags_addr, 64'h0000_0001_0000_0001);
    fill_page(1'b0, pa, 1'b0, 1'b0);          // private to context 1234.
    expect_lookup(1'b0, pa, 1'b1, 1'b0);
    expect_lookup(1'b1, pa, 1'b0, 1'b0);
    fill_page(1'b1, pb, 1'b1, 1'b0);
    expect_lookup(1'b0, pb, 1'b1, 1'b0);
    write_csr(csr_flags_addr, 64'h0);         // both threads back to context 0.
    expect_lookup(1'b0, pa, 1'b0, 1'b0);
    fill_page(1'b0, pc, 1'b0, 1'b0);
    expect_lookup(1'b1, pc, 1'b1, 1'b0);
    write_csr(csr_flags_addr, 64'h0000_0001_0000_0000);
    expect_lookup(1'b1, pc, 1'b0, 1'b0);
    expect_lookup(1'b0, pc, 1'b1, 1'b0);
    expect_lookup(1'b1, pb, 1'b1, 1'b0);
  endtask

  task automatic stall_directed();
    logic [vpn_bits-1:0] pg [10];
    for (int i = 0; i < 10; i++)
      pg[i] = {30'($random(seed)), 6'd30};
    for (int i = 0; i < way_count; i++)
      fill_page(1'b0, pg[i], 1'b1, 1'b0);     // eight fills rotate through the whole set.
    expect_lookup(1'b0, pg[0], 1'b1, 1'b1);
    expect_lookup(1'b1, pg[0], 1'b1, 1'b1);
    fill_page(1'b0, pg[8], 1'b1, 1'b1);       // oldest page goes despite the stalled hits.
    expect_lookup(1'b0, pg[8], 1'b1, 1'b0);
    expect_lookup(1'b0, pg[0], 1'b0, 1'b0);
    expect_lookup(1'b0, pg[1], 1'b1, 1'b0);
    fill_page(1'b0, pg[9], 1'b1, 1'b0);
    expect_lookup(1'b0, pg[2], 1'b0, 1'b0);
    expect_lookup(1'b0, pg[1], 1'b1, 1'b0);
  endtask

  initial
  begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog timeout, the test did not finish in %0d cycles", watchdog_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    seed = 20;
    err_cnt = 0;
    check_cnt = 0;
    rst = 1'b1;
    lookup_en = 1'b0;
    lookup_thread = 1'b0;
    lookup_addr = '0;
    stall = 1'b0;
    fill_en = 1'b0;
    fill_data = '0;
    csr_wr = '0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    check_init();
    model_reset();
    make_pool(set_count);
    random_cycles(basic_cycles, 30, 20, 0);
    context_directed();
    random_cycles(ctx_cycles, 30, 20, 10);
    stall_directed();
    make_pool(3);                             // three sets make evictions frequent.
    random_cycles(repl_cycles, 40, 30, 5);
    @(posedge clk);
    $display("Checks: %0d, check errors: %0d, assertion errors: %0d", check_cnt, err_cnt,
             UUT.chk.assert_fails);
    if (err_cnt == 0 && UUT.chk.assert_fails == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== all.f ====
common/tlb_pkg.sv
common/csr_pkg.sv
logic/csr_watch.sv
ctlb/ctlb_lru.sv
ctlb/ctlb_way.sv
ctlb/ctlb.sv
dv/tb_clock.sv
dv/ctlb_chk.sv
dv/ctlb_tb.sv
